//--- files.f
logic/cntTypesPkg.sv
logic/cntTimingPkg.sv
logic/cntTickIf.sv
logic/edgeSync.sv
logic/refreshTimer.sv
logic/startupSequencer.sv
logic/qosGovernor.sv
logic/apbRegs.sv
logic/cntTop.sv
testbench/cntTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only -Wall --timing
TOP = cntTb
FILELIST = files.f
OBJDIR = obj_dir
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "Simulation failed."; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- testbench/cntTb.sv
module cntTb;

	// Four periods per stage keeps startup short.
	localparam int LongPeriods = 4;
	// Eleven E cycles per refresh period.
	localparam int RefreshSteps = 11;
	localparam int UrgentStep = 9;
	localparam int StageFalls = RefreshSteps * LongPeriods;

	logic CLK, rstN;
	// Slow clocks, NMI button and host reset.
	logic E, C8M, nIPL2, nRESin;
	logic BACT, BACTr, IOQoSCS, SndQoSCS, IACKCS;
	logic RefReq, RefUrg, nRESout, nBR_IOB, AoutOE, IOQoSEN, MCKE;
	logic psel, penable, pwrite, pready, pslverr;
	logic [cntTimingPkg::ApbAddrWidth-1:0] paddr;
	logic [cntTimingPkg::ApbDataWidth-1:0] pwdata, prdata;

	// CLK cycles within one E period and one C8M half period.
	int phase, c8mPhase;
	// E falls driven since reset.
	int fallCount;
	// Expected sequence state and NMI latch.
	cntTypesPkg::startupState modelState;
	logic nmiSeen;

	int seed, checkCount, errorCount;

	cntTop #(.LongPeriods(LongPeriods)) dut (.*);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		assert (actual === expected) else begin
			errorCount++;
			$display("FAILED t=%0t %s expected %0h got %0h", $time, name, expected, actual);
		end
	endtask

	task automatic reportTimeout(input string what);
		errorCount++;
		$display("timeout: %s did not happen by time %0t", what, $time);
	endtask

	task automatic reportTest(input string name, input int errors);
		$display("%s: finished with %0d errors", name, errors);
	endtask

	// Seventh cycle after an E fall.
	// All effects of that fall have settled.
	task automatic waitQuiet();
		int n;
		n = 0;
		while (phase != 6 && n < 25) begin
			@(posedge CLK);
			n++;
		end
		if (n >= 25) reportTimeout("quiet phase");
	endtask

	// One APB transfer, setup then access.
	task automatic busTransfer(input logic write, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int n;
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge CLK);
		penable <= 1'b1;
		n = 0;
		@(posedge CLK);
		while (!pready && n < 8) begin
			@(posedge CLK);
			n++;
		end
		if (n >= 8) reportTimeout("APB pready");
		rdata = prdata;
		err = pslverr;
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	// Clock enable follows bus activity one cycle later.
	assert property (@(posedge CLK) disable iff (!rstN) (BACT || BACTr) |=> MCKE)
		else begin
			errorCount++;
			$display("FAILED t=%0t MCKE expected 1 got %0b", $time, $sampled(MCKE));
		end

	// E half period 10 CLK, C8M half period 3 CLK.
	always @(posedge CLK) begin
		phase <= (phase == 19) ? 0 : phase + 1;
		c8mPhase <= (c8mPhase == 2) ? 0 : c8mPhase + 1;
		if (c8mPhase == 2) C8M <= !C8M;
		if (phase == 9) E <= 1'b1;
		if (phase == 19) begin
			// Outputs still show the step of the last fall.
			checkValue("RefReq", (fallCount % RefreshSteps) != 0, RefReq);
			checkValue("RefUrg", (fallCount % RefreshSteps) >= UrgentStep, RefUrg);
			checkValue("nRESout", modelState == cntTypesPkg::running, nRESout);
			checkValue("nBR_IOB", nmiSeen, nBR_IOB);
			checkValue("AoutOE", (modelState == cntTypesPkg::driveBus ||
				modelState == cntTypesPkg::running) && !nmiSeen, AoutOE);
			E <= 1'b0;
			fallCount <= fallCount + 1;
			// Stage ends with every fourth period.
			if ((fallCount + 1) % StageFalls == 0) begin
				case (modelState)
					cntTypesPkg::holdReset: modelState <= cntTypesPkg::requestBus;
					cntTypesPkg::requestBus: modelState <= cntTypesPkg::driveBus;
					cntTypesPkg::driveBus: modelState <= cntTypesPkg::running;
					default: modelState <= modelState;
				endcase
			end
		end
	end

	initial begin
		logic [31:0] rdata;
		logic [31:0] expStatus;
		logic [31:0] r;
		logic err;
		int mark, n, reload, startPeriods, passed;
		seed = 63889;
		checkCount = 0;
		errorCount = 0;
		phase = 0;
		c8mPhase = 0;
		fallCount = 0;
		nmiSeen = 1'b0;
		modelState = cntTypesPkg::holdReset;
		rstN = 1'b0;
		{E, C8M} = 2'b00;
		{nIPL2, nRESin} = 2'b11;
		{BACT, BACTr, IOQoSCS, SndQoSCS, IACKCS} = '0;
		{psel, penable, pwrite} = '0;
		paddr = '0;
		pwdata = '0;
		repeat (2) @(posedge CLK);
		rstN <= 1'b1;

		// Startup with an NMI press in requestBus.
		mark = errorCount;
		n = 0;
		while (modelState != cntTypesPkg::requestBus && n < StageFalls * 20 + 100) begin
			@(posedge CLK);
			n++;
		end
		if (n >= StageFalls * 20 + 100) reportTimeout("requestBus stage");
		waitQuiet();
		nIPL2 <= 1'b0;
		nmiSeen <= 1'b1;
		repeat (3) @(posedge CLK);
		nIPL2 <= 1'b1;
		n = 0;
		while (nBR_IOB !== 1'b1 && n < 10) begin
			@(posedge CLK);
			n++;
		end
		if (n >= 10) reportTimeout("bus request withdrawal");
		n = 0;
		while (nRESout !== 1'b1 && n < 3 * StageFalls * 20) begin
			@(posedge CLK);
			n++;
		end
		if (n >= 3 * StageFalls * 20) reportTimeout("host reset release");
		checkValue("E falls at release", 3 * StageFalls, fallCount);
		reportTest("startup", errorCount - mark);

		// Register port.
		mark = errorCount;
		waitQuiet();
		busTransfer(1'b0, cntTypesPkg::regRefCount, '0, rdata, err);
		checkValue("regRefCount", fallCount / RefreshSteps, rdata);
		checkValue("pslverr", 0, err);
		busTransfer(1'b0, cntTypesPkg::regStatus, '0, rdata, err);
		expStatus = {27'd0, IOQoSEN, (fallCount % RefreshSteps) >= UrgentStep,
			(fallCount % RefreshSteps) != 0, modelState};
		checkValue("regStatus", expStatus, rdata);
		busTransfer(1'b1, cntTypesPkg::regQosReload, 32'hABCD_1236, rdata, err);
		checkValue("pslverr", 0, err);
		busTransfer(1'b0, cntTypesPkg::regQosReload, '0, rdata, err);
		checkValue("regQosReload", 32'h6, rdata);
		busTransfer(1'b1, cntTypesPkg::regStatus, 32'h1, rdata, err);
		checkValue("pslverr", 1, err);
		busTransfer(1'b0, 8'h0C, '0, rdata, err);
		checkValue("pslverr", 1, err);
		reportTest("register port", errorCount - mark);

		// QoS hold after one I/O cycle.
		// Reload above the count left since reset.
		mark = errorCount;
		reload = 5;
		busTransfer(1'b1, cntTypesPkg::regQosReload, 32'h0000_FFF5, rdata, err);
		waitQuiet();
		startPeriods = fallCount / RefreshSteps;
		BACT <= 1'b1;
		IOQoSCS <= 1'b1;
		@(posedge CLK);
		BACT <= 1'b0;
		IOQoSCS <= 1'b0;
		repeat (3) @(posedge CLK);
		checkValue("IOQoSEN", 1, IOQoSEN);
		n = 0;
		while (IOQoSEN !== 1'b0 && n < (reload + 2) * RefreshSteps * 20) begin
			@(posedge CLK);
			n++;
		end
		if (n >= (reload + 2) * RefreshSteps * 20) reportTimeout("IOQoSEN fall");
		passed = fallCount / RefreshSteps - startPeriods;
		checkCount++;
		assert (passed >= reload && passed <= reload + 1) else begin
			errorCount++;
			$display("FAILED t=%0t IOQoSEN period ends expected %0d to %0d got %0d",
				$time, reload, reload + 1, passed);
		end
		reportTest("qos", errorCount - mark);

		// Random bus activity for MCKE.
		mark = errorCount;
		for (n = 0; n < 200; n++) begin
			r = $random(seed);
			{IACKCS, SndQoSCS, IOQoSCS, BACTr, BACT} <= r[4:0];
			@(posedge CLK);
		end
		{BACT, BACTr, IOQoSCS, SndQoSCS, IACKCS} <= '0;
		@(posedge CLK);
		reportTest("bus activity", errorCount - mark);

		// Host reset pulse restarts the sequence.
		mark = errorCount;
		waitQuiet();
		nRESin <= 1'b0;
		modelState <= cntTypesPkg::holdReset;
		nmiSeen <= 1'b0;
		repeat (3) @(posedge CLK);
		nRESin <= 1'b1;
		n = 0;
		while (nRESout !== 1'b0 && n < 10) begin
			@(posedge CLK);
			n++;
		end
		if (n >= 10) reportTimeout("host reset after nRESin");
		n = 0;
		while (nRESout !== 1'b1 && n < 4 * StageFalls * 20 + 100) begin
			@(posedge CLK);
			n++;
		end
		if (n >= 4 * StageFalls * 20 + 100) reportTimeout("second release");
		checkValue("AoutOE", 1, AoutOE);
		checkValue("nBR_IOB", 0, nBR_IOB);
		reportTest("reset return", errorCount - mark);

		$display("refresh pattern: %0d E falls checked", fallCount);
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- logic/cntTop.sv
module cntTop #(
	parameter int LongPeriods = cntTimingPkg::LongPeriodsDefault
) (
	input logic CLK,
	input logic rstN,
	// Slow clocks, button, host reset.
	input logic E,
	input logic C8M,
	input logic nIPL2,
	input logic nRESin,
	// Bus activity from the decoder.
	input logic BACT,
	input logic BACTr,
	input logic IOQoSCS,
	input logic SndQoSCS,
	input logic IACKCS,
	// Refresh requests.
	output logic RefReq,
	output logic RefUrg,
	// Host reset and bus mastering.
	output logic nRESout,
	output logic nBR_IOB,
	output logic AoutOE,
	// QoS and clock enable.
	output logic IOQoSEN,
	output logic MCKE,
	// APB register port.
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [cntTimingPkg::ApbAddrWidth-1:0] paddr,
	input logic [cntTimingPkg::ApbDataWidth-1:0] pwdata,
	output logic [cntTimingPkg::ApbDataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	cntTickIf tick ();

	logic [cntTimingPkg::RefCountWidth-1:0] refCount;
	logic [cntTimingPkg::QosWidth-1:0] qosReload;
	cntTypesPkg::startupState seqState;

	edgeSync uSync (
		.CLK(CLK), .rstN(rstN), .E(E), .C8M(C8M),
		.nIPL2(nIPL2), .nRESin(nRESin), .tick(tick)
	);

	refreshTimer #(.LongPeriods(LongPeriods)) uTimer (
		.CLK(CLK), .rstN(rstN), .tick(tick),
		.RefReq(RefReq), .RefUrg(RefUrg), .refCount(refCount)
	);

	startupSequencer uSeq (
		.CLK(CLK), .rstN(rstN), .tick(tick), .nRESout(nRESout),
		.nBR_IOB(nBR_IOB), .AoutOE(AoutOE), .seqState(seqState)
	);

	qosGovernor uQos (
		.CLK(CLK), .rstN(rstN), .BACT(BACT), .BACTr(BACTr),
		.IOQoSCS(IOQoSCS), .SndQoSCS(SndQoSCS), .IACKCS(IACKCS),
		.qosReload(qosReload), .tick(tick), .IOQoSEN(IOQoSEN), .MCKE(MCKE)
	);

	apbRegs uRegs (
		.CLK(CLK), .rstN(rstN), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .seqState(seqState),
		.RefReq(RefReq), .RefUrg(RefUrg), .IOQoSEN(IOQoSEN),
		.refCount(refCount), .qosReload(qosReload)
	);

endmodule

//--- logic/apbRegs.sv
module apbRegs (
	input logic CLK,
	input logic rstN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [cntTimingPkg::ApbAddrWidth-1:0] paddr,
	input logic [cntTimingPkg::ApbDataWidth-1:0] pwdata,
	output logic [cntTimingPkg::ApbDataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input cntTypesPkg::startupState seqState,
	input logic RefReq,
	input logic RefUrg,
	input logic IOQoSEN,
	input logic [cntTimingPkg::RefCountWidth-1:0] refCount,
	output logic [cntTimingPkg::QosWidth-1:0] qosReload
);

	typedef logic [cntTimingPkg::ApbDataWidth-1:0] apbWord;

	logic access;
	logic addrKnown;
	logic readOnly;

	// Second cycle of a transfer.
	assign access = psel && penable;

	// No wait states.
	assign pready = 1'b1;

	// Address decode and read mux.
	always_comb begin
		prdata = '0;
		addrKnown = 1'b1;
		readOnly = 1'b1;
		case (paddr)
			cntTypesPkg::regStatus: begin
				// IOQoSEN, RefUrg, RefReq, state from bit 4 down.
				prdata = apbWord'({IOQoSEN, RefUrg, RefReq, seqState});
			end
			cntTypesPkg::regQosReload: begin
				prdata = apbWord'(qosReload);
				readOnly = 1'b0;
			end
			cntTypesPkg::regRefCount: begin
				prdata = apbWord'(refCount);
			end
			default: begin
				addrKnown = 1'b0;
				readOnly = 1'b0;
			end
		endcase
	end

	// Error in the access cycle only.
	assign pslverr = access && (!addrKnown || (pwrite && readOnly));

	// Reload register write.
	// Upper data bits dropped.
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			qosReload <= cntTimingPkg::QosReloadDefault;
		end else if (access && pwrite && paddr == cntTypesPkg::regQosReload) begin
			qosReload <= pwdata[cntTimingPkg::QosWidth-1:0];
		end
	end

endmodule

//--- logic/qosGovernor.sv
module qosGovernor (
	input logic CLK,
	input logic rstN,
	input logic BACT,
	input logic BACTr,
	input logic IOQoSCS,
	input logic SndQoSCS,
	input logic IACKCS,
	input logic [cntTimingPkg::QosWidth-1:0] qosReload,
	cntTickIf.user tick,
	output logic IOQoSEN,
	output logic MCKE
);

	// Registered select term.
	logic qosSel;
	logic [cntTimingPkg::QosWidth-1:0] qosCount;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			qosSel <= 1'b0;
			// Countdown starts full.
			qosCount <= cntTimingPkg::QosReloadDefault;
			IOQoSEN <= 1'b1;
			MCKE <= 1'b1;
		end else begin
			// I/O, sound or IACK cycle, or host reset.
			qosSel <= (BACT && (IOQoSCS || SndQoSCS || IACKCS)) || !tick.resInN;
			// Reload wins, else one step per period.
			if (qosSel) begin
				qosCount <= qosReload;
			end else if (tick.periodEnd && qosCount != '0) begin
				qosCount <= qosCount - 1'b1;
			end
			// Change QoS only between bus cycles.
			if (!BACT) begin
				IOQoSEN <= (qosCount != '0);
			end
			// Run during bus activity or with QoS off.
			// Else one clock per C8M cycle.
			MCKE <= BACT || BACTr || !IOQoSEN || tick.c8mFall;
		end
	end

endmodule

//--- logic/startupSequencer.sv
module startupSequencer (
	input logic CLK,
	input logic rstN,
	cntTickIf.user tick,
	output logic nRESout,
	output logic nBR_IOB,
	output logic AoutOE,
	output cntTypesPkg::startupState seqState
);

	cntTypesPkg::startupState state;

	// Armed one eFall after release.
	// Blocks a stale reset-in right at release.
	logic lookReset;

	assign seqState = state;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			lookReset <= 1'b0;
		end else if (!nRESout) begin
			lookReset <= 1'b0;
		end else if (tick.eFall) begin
			lookReset <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			state <= cntTypesPkg::holdReset;
			nRESout <= 1'b0;
			nBR_IOB <= 1'b0;
			AoutOE <= 1'b0;
		end else begin
			case (state)
				cntTypesPkg::holdReset: begin
					// Host in reset, bus lines tristated.
					AoutOE <= 1'b0;
					nRESout <= 1'b0;
					// Request the bus at once.
					nBR_IOB <= 1'b0;
					if (tick.initDone) begin
						state <= cntTypesPkg::requestBus;
					end
				end
				cntTypesPkg::requestBus: begin
					AoutOE <= 1'b0;
					nRESout <= 1'b0;
					// NMI drops the request for good.
					nBR_IOB <= nBR_IOB || !tick.nmiN;
					// Wait while the button is held.
					if (tick.initDone && tick.nmiN) begin
						state <= cntTypesPkg::driveBus;
					end
				end
				cntTypesPkg::driveBus: begin
					// Drive only if the bus is ours.
					AoutOE <= !nBR_IOB;
					nRESout <= 1'b0;
					if (tick.initDone) begin
						state <= cntTypesPkg::running;
					end
				end
				cntTypesPkg::running: begin
					// Release the host.
					nRESout <= 1'b1;
					if (lookReset && !tick.resInN) begin
						state <= cntTypesPkg::holdReset;
					end
				end
				default: begin
					state <= cntTypesPkg::holdReset;
				end
			endcase
		end
	end

endmodule

//--- logic/refreshTimer.sv
module refreshTimer #(
	parameter int LongPeriods = cntTimingPkg::LongPeriodsDefault
) (
	input logic CLK,
	input logic rstN,
	cntTickIf.timerSide tick,
	output logic RefReq,
	output logic RefUrg,
	output logic [cntTimingPkg::RefCountWidth-1:0] refCount
);

	// Long timer width, at least one bit.
	localparam int LongWidth = (LongPeriods > 1) ? $clog2(LongPeriods) : 1;

	logic [cntTimingPkg::TimerWidth-1:0] step;
	logic [cntTimingPkg::TimerWidth-1:0] stepNext;
	logic lastStep;

	logic [LongWidth-1:0] longCount;
	logic longLast;

	// Step sequence 0..10, then back to 0.
	assign lastStep = (step == cntTimingPkg::RefreshLast);
	assign stepNext = lastStep ? '0 : step + 1'b1;

	// Period end on the eFall of the last step.
	assign tick.periodEnd = tick.eFall && lastStep;

	// Stage end when the long timer wraps.
	assign longLast = (longCount == LongWidth'(LongPeriods - 1));
	assign tick.initDone = tick.periodEnd && longLast;

	// Step counter and refresh flags.
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			step <= '0;
			RefReq <= 1'b0;
			RefUrg <= 1'b0;
		end else if (tick.eFall) begin
			step <= stepNext;
			// No request in step 0 only.
			RefReq <= (stepNext != '0);
			// Urgent in the last two steps.
			RefUrg <= (stepNext >= cntTimingPkg::UrgentFirst);
		end
	end

	// Long timer and period count.
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			longCount <= '0;
			refCount <= '0;
		end else if (tick.periodEnd) begin
			if (longLast) begin
				longCount <= '0;
			end else begin
				longCount <= longCount + 1'b1;
			end
			// Free count, wraps.
			refCount <= refCount + 1'b1;
		end
	end

endmodule

//--- logic/edgeSync.sv
module edgeSync (
	input logic CLK,
	input logic rstN,
	input logic E,
	input logic C8M,
	input logic nIPL2,
	input logic nRESin,
	cntTickIf.syncSide tick
);

	// Two-stage samplers.
	// Bit 0 is the newest sample.
	logic [1:0] eSync;
	logic [1:0] c8mSync;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			eSync <= 2'b00;
			c8mSync <= 2'b00;
			tick.eFall <= 1'b0;
			tick.c8mFall <= 1'b0;
			// Inactive levels.
			tick.nmiN <= 1'b1;
			tick.resInN <= 1'b1;
		end else begin
			eSync <= {eSync[0], E};
			c8mSync <= {c8mSync[0], C8M};
			// Fall seen as old high, new low.
			// Registered strobe, one cycle wide.
			tick.eFall <= eSync[1] && !eSync[0];
			tick.c8mFall <= c8mSync[1] && !c8mSync[0];
			// Button and reset-in, one stage.
			tick.nmiN <= nIPL2;
			tick.resInN <= nRESin;
		end
	end

endmodule

//--- logic/cntTickIf.sv
interface cntTickIf;

	// Synchronized strobes and levels.
	logic eFall;
	logic c8mFall;
	logic nmiN;
	logic resInN;

	// Refresh timer events.
	// Both are one-cycle strobes on eFall.
	logic periodEnd;
	logic initDone;

	modport syncSide (
		output eFall, c8mFall, nmiN, resInN
	);

	modport timerSide (
		input eFall,
		output periodEnd, initDone
	);

	modport user (
		input eFall, c8mFall, nmiN, resInN, periodEnd, initDone
	);

endinterface

//--- logic/cntTimingPkg.sv
package cntTimingPkg;

	// Refresh timer.
	// One period is eleven E cycles.
	localparam int RefreshSteps = 11;
	localparam int TimerWidth = 4;
	localparam logic [TimerWidth-1:0] RefreshLast = TimerWidth'(RefreshSteps - 1);
	// Urgent from step 9 on.
	localparam logic [TimerWidth-1:0] UrgentFirst = TimerWidth'(9);

	// Refresh periods per startup stage.
	localparam int LongPeriodsDefault = 2048;

	// I/O QoS countdown.
	localparam int QosWidth = 4;
	localparam logic [QosWidth-1:0] QosReloadDefault = QosWidth'(15);

	// Register port widths.
	localparam int RefCountWidth = 16;
	localparam int ApbDataWidth = 32;
	localparam int ApbAddrWidth = 8;

endpackage

//--- logic/cntTypesPkg.sv
package cntTypesPkg;

	// Power-up sequence steps.
	// holdReset and requestBus keep the host in reset.
	typedef enum logic [1:0] {
		holdReset  = 2'd0,
		requestBus = 2'd1,
		driveBus   = 2'd2,
		running    = 2'd3
	} startupState;

	// APB register map.
	// Byte offsets of 32-bit words.
	typedef enum logic [7:0] {
		// Sequence state and timing flags.
		regStatus    = 8'h00,
		// QoS countdown reload, read/write.
		regQosReload = 8'h04,
		// Refresh periods since reset.
		regRefCount  = 8'h08
	} regAddr;

endpackage
